//--- hdl/wb_pkg.sv
// Wishbone bus definitions
// Bus widths, field typedefs and the packed request and response
// structs shared by every block on the bus
`default_nettype none

package wb_pkg;

	localparam int WB_ADDR_WIDTH = 32;
	localparam int WB_DATA_WIDTH = 32;
	localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;

	typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
	typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;
	typedef logic [WB_SEL_WIDTH-1:0]  wb_sel_t;
	typedef logic [2:0]               wb_cti_t;
	typedef logic [1:0]               wb_bte_t;

	// Master to target, 76 bits
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		wb_addr_t adr;
		wb_data_t dat_w;
		wb_sel_t  sel;
		wb_cti_t  cti;
		wb_bte_t  bte;
	} wb_req_t;

	// Target to master, 34 bits
	typedef struct packed {
		logic     ack;
		logic     err;
		wb_data_t dat_r;
	} wb_rsp_t;

endpackage

`default_nettype wire

//--- hdl/icon_pkg.sv
// Interconnect shape
// Master and destination counts, the target address window and
// the id types used between master ports, arbiters and the mux
`default_nettype none

package icon_pkg;

	localparam int N_MASTERS = 4;
	localparam int N_DEST    = 2;

	// Inclusive window of the external target
	localparam logic [31:0] TGT_ADDR_BASE  = 32'h0000_0000;
	localparam logic [31:0] TGT_ADDR_LIMIT = 32'h0000_0FFF;

	typedef logic [1:0] master_id_t;
	typedef logic [0:0] dest_id_t;

	// Destination indices
	localparam dest_id_t DEST_TGT = 1'b0;
	localparam dest_id_t DEST_ERR = 1'b1;

	typedef enum logic {PORT_IDLE, PORT_BUSY} port_state_e;

endpackage

`default_nettype wire

//--- hdl/wb_master_port.sv
// Wishbone master port
// Decodes the address of a new request against the target window and
// holds the chosen destination until the routed response ends the beat
`timescale 1ns/1ps
`default_nettype none

module wb_master_port
	import wb_pkg::*;
	import icon_pkg::*;
(
	input  wire             clk,
	input  wire             rstn,
	input  wire wb_req_t    req_i,
	input  wire wb_rsp_t    rsp_i,
	output logic [N_DEST-1:0] dest_req_o,
	output dest_id_t        dest_o
);

	port_state_e state_q;
	dest_id_t    dest_q;
	dest_id_t    dest_dec;

	// Anything outside the window goes to the error responder
	assign dest_dec = (req_i.adr >= TGT_ADDR_BASE && req_i.adr <= TGT_ADDR_LIMIT) ?
		DEST_TGT : DEST_ERR;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= PORT_IDLE;
			dest_q  <= DEST_TGT;
		end else begin
			case (state_q)
				PORT_IDLE: begin
					if (req_i.cyc && req_i.stb) begin
						state_q <= PORT_BUSY;
						dest_q  <= dest_dec;
					end
				end
				PORT_BUSY: begin
					// Beat ends on either response
					if (rsp_i.ack || rsp_i.err) begin
						state_q <= PORT_IDLE;
					end
				end
				default: state_q <= PORT_IDLE;
			endcase
		end
	end

	always_comb begin
		dest_req_o = '0;
		if (state_q == PORT_BUSY) begin
			dest_req_o[dest_q] = 1'b1;
		end
	end

	assign dest_o = dest_q;

	a_dest_onehot: assert property (@(posedge clk) disable iff (!rstn)
		$onehot0(dest_req_o));

endmodule

`default_nettype wire

//--- hdl/wb_rr_arbiter.sv
// Round-robin arbiter for one destination
// Picks the lowest requester above the last grant, else the lowest
// overall, and keeps the grant until the owner drops its request
`timescale 1ns/1ps
`default_nettype none

module wb_rr_arbiter
	import icon_pkg::*;
(
	input  wire                 clk,
	input  wire                 rstn,
	input  wire [N_MASTERS-1:0] req_i,
	output logic                gnt_o,
	output master_id_t          gnt_id_o
);

	// One-hot of the last grant, also the current owner while gnt_o is high
	logic [N_MASTERS-1:0] last_q;
	logic [N_MASTERS-1:0] above_mask;
	logic [N_MASTERS-1:0] masked_req;
	logic [N_MASTERS-1:0] cand;
	logic [N_MASTERS-1:0] pick;

	function automatic master_id_t onehot_to_id(input logic [N_MASTERS-1:0] oh);
		master_id_t id;
		id = '0;
		for (int i = 0; i < N_MASTERS; i++) begin
			if (oh[i]) begin
				id = master_id_t'(i);
			end
		end
		return id;
	endfunction

	// Bits strictly above the last grant, empty after reset
	assign above_mask = ~((last_q << 1) - N_MASTERS'(1));
	assign masked_req = req_i & above_mask;
	assign cand       = (|masked_req) ? masked_req : req_i;

	// Isolate lowest set bit
	assign pick = cand & (~cand + N_MASTERS'(1));

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o    <= 1'b0;
			gnt_id_o <= '0;
			last_q   <= '0;
		end else if (!gnt_o) begin
			if (|req_i) begin
				gnt_o    <= 1'b1;
				gnt_id_o <= onehot_to_id(pick);
				last_q   <= pick;
			end
		end else if (!req_i[gnt_id_o]) begin
			// Owner is done, free for the next edge
			gnt_o <= 1'b0;
		end
	end

	// A held grant always belongs to a master that requested on the last edge
	a_gnt_owner_req: assert property (@(posedge clk) disable iff (!rstn)
		gnt_o |-> |($past(req_i) & last_q));

endmodule

`default_nettype wire

//--- hdl/wb_target_mux.sv
// Wishbone target multiplexer
// Routes each destination's granted request, sends responses back to
// the owning master only, and answers out-of-window beats with ERR
`timescale 1ns/1ps
`default_nettype none

module wb_target_mux
	import wb_pkg::*;
	import icon_pkg::*;
(
	input  wire              clk,
	input  wire              rstn,
	input  wire wb_req_t     m_req_i [N_MASTERS],
	input  wire dest_id_t    m_dest_i [N_MASTERS],
	input  wire [N_DEST-1:0] gnt_i,
	input  wire master_id_t  gnt_id_i [N_DEST],
	output wb_req_t          t_req_o,
	input  wire wb_rsp_t     t_rsp_i,
	output wb_rsp_t          m_rsp_o [N_MASTERS]
);

	wb_req_t           dst_req [N_DEST];
	wb_rsp_t           dst_rsp [N_DEST];
	logic [N_DEST-1:0] done_q;
	logic              err_q;
	logic [N_MASTERS-1:0] rsp_hit [N_DEST];

	// Owner's request; stb is masked once its beat has completed
	// so the gap before the grant drops is not seen as a new beat
	always_comb begin
		for (int d = 0; d < N_DEST; d++) begin
			dst_req[d] = '0;
			if (gnt_i[d]) begin
				dst_req[d] = m_req_i[gnt_id_i[d]];
				dst_req[d].stb = m_req_i[gnt_id_i[d]].stb & ~done_q[d];
			end
		end
	end

	assign t_req_o          = dst_req[DEST_TGT];
	assign dst_rsp[DEST_TGT] = t_rsp_i;
	assign dst_rsp[DEST_ERR] = '{ack: 1'b0, err: err_q, dat_r: '0};

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q  <= 1'b0;
			done_q <= '0;
		end else begin
			// Decode error, one cycle of err per beat
			err_q <= dst_req[DEST_ERR].cyc && dst_req[DEST_ERR].stb && !err_q;
			for (int d = 0; d < N_DEST; d++) begin
				if (!gnt_i[d]) begin
					done_q[d] <= 1'b0;
				end else if (dst_req[d].stb && (dst_rsp[d].ack || dst_rsp[d].err)) begin
					done_q[d] <= 1'b1;
				end
			end
		end
	end

	always_comb begin
		dest_id_t d;
		d = '0;
		for (int m = 0; m < N_MASTERS; m++) begin
			d = m_dest_i[m];
			m_rsp_o[m] = '0;
			if (gnt_i[d] && !done_q[d] && gnt_id_i[d] == master_id_t'(m)) begin
				m_rsp_o[m] = dst_rsp[d];
			end
		end
	end

	// Masters seeing a response, grouped by destination
	always_comb begin
		for (int d = 0; d < N_DEST; d++) begin
			for (int m = 0; m < N_MASTERS; m++) begin
				rsp_hit[d][m] = (m_rsp_o[m].ack || m_rsp_o[m].err) &&
					(m_dest_i[m] == dest_id_t'(d));
			end
		end
	end

	for (genvar g = 0; g < N_DEST; g++) begin : g_rsp_chk
		a_one_rsp: assert property (@(posedge clk) disable iff (!rstn)
			$onehot0(rsp_hit[g]));
	end

endmodule

`default_nettype wire

//--- hdl/wb_interconnect_4x1.sv
// Wishbone classic interconnect, four masters to one target
// Master ports decode and track requests, one arbiter per destination,
// and the mux routes to the target or the decode-error responder
`timescale 1ns/1ps
`default_nettype none

module wb_interconnect_4x1
	import wb_pkg::*;
	import icon_pkg::*;
(
	input  wire          clk,
	input  wire          rstn,
	input  wire wb_req_t m_req_i [N_MASTERS],
	output wb_rsp_t      m_rsp_o [N_MASTERS],
	output wb_req_t      t_req_o,
	input  wire wb_rsp_t t_rsp_i
);

	logic [N_DEST-1:0]    dest_req [N_MASTERS];
	dest_id_t             m_dest [N_MASTERS];
	logic [N_MASTERS-1:0] arb_req [N_DEST];
	logic [N_DEST-1:0]    gnt;
	master_id_t           gnt_id [N_DEST];

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_port
		wb_master_port u_port (
			.clk        (clk),
			.rstn       (rstn),
			.req_i      (m_req_i[m]),
			.rsp_i      (m_rsp_o[m]),
			.dest_req_o (dest_req[m]),
			.dest_o     (m_dest[m])
		);
	end

	for (genvar d = 0; d < N_DEST; d++) begin : g_arb
		// Column d of the per-master request vectors
		for (genvar m = 0; m < N_MASTERS; m++) begin : g_bit
			assign arb_req[d][m] = dest_req[m][d];
		end

		wb_rr_arbiter u_arb (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (arb_req[d]),
			.gnt_o    (gnt[d]),
			.gnt_id_o (gnt_id[d])
		);
	end

	wb_target_mux u_mux (
		.clk      (clk),
		.rstn     (rstn),
		.m_req_i  (m_req_i),
		.m_dest_i (m_dest),
		.gnt_i    (gnt),
		.gnt_id_i (gnt_id),
		.t_req_o  (t_req_o),
		.t_rsp_i  (t_rsp_i),
		.m_rsp_o  (m_rsp_o)
	);

endmodule

`default_nettype wire

//--- tests/tb_wb_interconnect.sv
// Testbench for the four-master Wishbone interconnect
// Drives four masters, models the target memory and checks the DUT
// ports with concurrent assertions
`timescale 1ns/1ps
`default_nettype none

module tb_wb_interconnect
	import wb_pkg::*;
	import icon_pkg::*;
();

	localparam int N_PAIRS = 4;
	localparam int N_FAIR  = 8;
	// Write, read back and decode error per pair, then back-to-back reads
	localparam int BEATS   = 3 * N_PAIRS + N_FAIR;
	localparam int N_TXN   = N_MASTERS * BEATS;

	logic                 clk;
	logic                 rstn;
	wb_req_t              m_req [N_MASTERS];
	wb_rsp_t              m_rsp [N_MASTERS];
	wb_req_t              t_req;
	wb_req_t              t_req_prev;
	wb_rsp_t              t_rsp;
	wb_data_t             ref_mem [1024];
	wb_data_t             tgt_mem [1024];
	wb_data_t             exp_dat [N_MASTERS];
	logic [N_MASTERS-1:0] pend_tgt;
	logic [N_MASTERS-1:0] acks;
	logic [N_MASTERS-1:0] errs;
	logic [N_MASTERS-1:0] owner_hit;
	logic [N_MASTERS-1:0] skipped;
	// Masters waiting at k's last target service, and those served since
	logic [N_MASTERS-1:0] waited_q [N_MASTERS];
	logic [N_MASTERS-1:0] served_q [N_MASTERS];

	wb_interconnect_4x1 u_dut (
		.clk     (clk),
		.rstn    (rstn),
		.m_req_i (m_req),
		.m_rsp_o (m_rsp),
		.t_req_o (t_req),
		.t_rsp_i (t_rsp)
	);

	// Window base is zero
	function automatic logic in_window(input wb_addr_t adr);
		return adr <= TGT_ADDR_LIMIT;
	endfunction

	function automatic wb_data_t fill_word(input int idx);
		return wb_data_t'(32'h5A00_00C3 ^ (idx * 32'h0101_0107) ^ (idx << 20));
	endfunction

	function automatic wb_data_t merge_bytes(input wb_data_t old, input wb_data_t nw,
			input wb_sel_t sel);
		wb_data_t res;
		res = old;
		for (int b = 0; b < WB_SEL_WIDTH; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = nw[8*b +: 8];
			end
		end
		return res;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "Run stopped on first error");
	endtask

	task automatic fail_check(input string test, input logic [75:0] expv,
			input logic [75:0] actv);
		stop_run($sformatf("FAIL %s expected %0h actual %0h", test, expv, actv));
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Target memory, 0 to 3 wait states before each ack
	initial begin : target_model
		int unsigned wait_cyc;
		int          idx;
		for (int i = 0; i < 1024; i++) begin
			tgt_mem[i] = fill_word(i);
		end
		t_rsp = '0;
		forever begin
			@(posedge clk);
			if (rstn && t_req.cyc && t_req.stb) begin
				wait_cyc = $urandom_range(3, 0);
				repeat (wait_cyc) @(posedge clk);
				#1;
				idx = int'(t_req.adr[11:2]);
				t_rsp = '{ack: 1'b1, err: 1'b0, dat_r: t_req.we ? '0 : tgt_mem[idx]};
				if (t_req.we) begin
					tgt_mem[idx] = merge_bytes(tgt_mem[idx], t_req.dat_w, t_req.sel);
				end
				@(posedge clk);
				#1;
				t_rsp = '0;
			end
		end
	end

	// One classic beat, held until ack or err
	task automatic do_beat(input int k, input logic we, input wb_addr_t adr, input wb_sel_t sel);
		wb_data_t dat;
		int       idx;
		dat = $urandom();
		idx = int'(adr[11:2]);
		if (!we && in_window(adr)) begin
			exp_dat[k] = ref_mem[idx];
		end
		m_req[k] = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat, sel: sel,
			cti: 3'($urandom_range(7, 0)), bte: 2'($urandom_range(3, 0))};
		@(posedge clk);
		while (!(m_rsp[k].ack || m_rsp[k].err)) begin
			@(posedge clk);
		end
		#1;
		if (we && in_window(adr)) begin
			ref_mem[idx] = merge_bytes(ref_mem[idx], dat, sel);
		end
		m_req[k] = '0;
	endtask

	task automatic idle_gap();
		int unsigned n;
		n = $urandom_range(2, 0);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_master(input int k, input logic fair);
		wb_addr_t adr;
		for (int i = 0; i < (fair ? N_FAIR : N_PAIRS); i++) begin
			adr = wb_addr_t'(32'h400 * k + 4 * $urandom_range(255, 0));
			if (fair) begin
				do_beat(k, 1'b0, adr, 4'hF);
			end else begin
				do_beat(k, 1'b1, adr, 4'($urandom_range(15, 1)));
				do_beat(k, 1'b0, adr, 4'hF);
				idle_gap();
				do_beat(k, 1'b0, adr | 32'h0010_0000, 4'hF);
				idle_gap();
			end
		end
	endtask

	always_comb begin
		for (int k = 0; k < N_MASTERS; k++) begin
			pend_tgt[k]  = m_req[k].cyc && m_req[k].stb && in_window(m_req[k].adr);
			acks[k]      = m_rsp[k].ack;
			errs[k]      = m_rsp[k].err;
			owner_hit[k] = pend_tgt[k] && (t_req == m_req[k]);
			skipped[k]   = |(waited_q[k] & ~served_q[k]);
		end
	end

	// Scoreboard state for fairness
	always @(posedge clk) begin
		t_req_prev <= t_req;
		for (int k = 0; k < N_MASTERS; k++) begin
			if (!rstn) begin
				waited_q[k] <= '0;
				served_q[k] <= '0;
			end else if (acks[k]) begin
				waited_q[k] <= pend_tgt & ~(N_MASTERS'(1) << k);
				served_q[k] <= '0;
				for (int j = 0; j < N_MASTERS; j++) begin
					if (j != k) begin
						served_q[j][k] <= 1'b1;
					end
				end
			end
		end
	end

	for (genvar k = 0; k < N_MASTERS; k++) begin : g_chk
		a_ack_owner: assert property (@(posedge clk) disable iff (!rstn)
			m_rsp[k].ack |-> owner_hit[k])
			else fail_check("ack_routing", $sampled(m_req[k]), $sampled(t_req));
		a_err_rsp: assert property (@(posedge clk) disable iff (!rstn)
			m_rsp[k].err |-> m_req[k].stb && !in_window(m_req[k].adr) &&
				m_rsp[k] == 34'h1_0000_0000)
			else fail_check("decode_error", 76'(34'h1_0000_0000), 76'($sampled(m_rsp[k])));
		a_read_data: assert property (@(posedge clk) disable iff (!rstn)
			(m_rsp[k].ack && !m_req[k].we) |-> m_rsp[k].dat_r == exp_dat[k])
			else fail_check("read_after_write", 76'($sampled(exp_dat[k])),
				76'($sampled(m_rsp[k].dat_r)));
		a_round_robin: assert property (@(posedge clk) disable iff (!rstn)
			m_rsp[k].ack |-> !skipped[k])
			else fail_check("round_robin", 76'(0), 76'($sampled(skipped[k])));
	end

	a_single_ack: assert property (@(posedge clk) disable iff (!rstn) $onehot0(acks))
		else fail_check("single_ack", 76'(1), 76'($countones($sampled(acks))));
	a_tgt_window: assert property (@(posedge clk) disable iff (!rstn)
		t_req.stb |-> in_window(t_req.adr))
		else fail_check("decode_error_stb", 76'(TGT_ADDR_LIMIT), 76'($sampled(t_req.adr)));
	a_tgt_owner: assert property (@(posedge clk) disable iff (!rstn)
		t_req.stb |-> $onehot(owner_hit))
		else fail_check("target_routing", 76'(1), 76'($countones($sampled(owner_hit))));
	a_back_pressure: assert property (@(posedge clk) disable iff (!rstn)
		(t_req.stb && !t_rsp.ack) |=> t_req == t_req_prev)
		else fail_check("back_pressure", $sampled(t_req_prev), $sampled(t_req));
	a_reset_quiet: assert property (@(posedge clk)
		$rose(rstn) |-> !(|(acks | errs)) && !t_req.cyc && !t_req.stb)
		else fail_check("reset_state", 76'(0), 76'({$sampled(acks), $sampled(errs),
			$sampled(t_req.cyc), $sampled(t_req.stb)}));

	// Worst case of 40 cycles per beat
	initial begin : watchdog
		repeat (N_TXN * 40) @(posedge clk);
		stop_run("Watchdog expired before all bus beats completed");
	end

	initial begin : main
		void'($urandom(27314));
		rstn = 1'b0;
		for (int k = 0; k < N_MASTERS; k++) begin
			m_req[k] = '0;
		end
		for (int i = 0; i < 1024; i++) begin
			ref_mem[i] = fill_word(i);
		end
		repeat (4) @(posedge clk);
		#1;
		rstn = 1'b1;
		fork
			run_master(0, 1'b0);
			run_master(1, 1'b0);
			run_master(2, 1'b0);
			run_master(3, 1'b0);
		join
		// All four contend for the target back to back
		fork
			run_master(0, 1'b1);
			run_master(1, 1'b1);
			run_master(2, 1'b1);
			run_master(3, 1'b1);
		join
		repeat (4) @(posedge clk);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
hdl/wb_pkg.sv
hdl/icon_pkg.sv
hdl/wb_master_port.sv
hdl/wb_rr_arbiter.sv
hdl/wb_target_mux.sv
hdl/wb_interconnect_4x1.sv
tests/tb_wb_interconnect.sv

//--- Makefile
# Verilator build and run of the Wishbone interconnect testbench

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= tb_wb_interconnect
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
